// File: x86_opnd_params.svh
`ifndef X86_OPND_PARAMS_SVH
`define X86_OPND_PARAMS_SVH

// Opcode byte plus the longest body handled here
// (ModR/M, SIB, disp32 and imm32)
`define X86_INSTR_BYTES 11

// General registers in hardware order EAX through EDI
`define X86_NUM_GPR 8

// Width of the instruction body length
`define X86_LEN_W 4

// ModR/M mod value for register-direct operands
`define X86_MOD_REG_DIRECT 2'd3

// ModR/M rm codes with a special meaning when mod is not 3
`define X86_RM_SIB 3'd4
`define X86_RM_DISP32 3'd5

// SIB index and base codes that drop the register term
`define X86_SIB_NO_INDEX 3'd4
`define X86_SIB_NO_BASE 3'd5

`endif

// File: x86_opnd_pkg.sv
`include "x86_opnd_params.svh"

package x86_opnd_pkg;

  // One data or address word of the 32-bit core
  typedef logic [31:0] word_t;

  // Register selector, 0 is EAX and 7 is EDI
  typedef logic [2:0] regsel_t;

  // Register n sits in slice n of the packed file
  typedef word_t [`X86_NUM_GPR-1:0] gpr_file_t;

  // Byte 0 is the opcode in bits 7:0, later bytes follow upward
  typedef logic [`X86_INSTR_BYTES*8-1:0] instr_bytes_t;

  // Body length in bytes, not counting the opcode
  typedef logic [`X86_LEN_W-1:0] body_len_t;

  // SIB scale, the index is shifted left by this amount
  typedef logic [1:0] scale_t;

  // Operand forms, operand 0 is listed first in each name
  typedef enum logic [3:0] {
    FORM_NONE         = 4'd0,
    FORM_REG          = 4'd1,
    FORM_IMM          = 4'd2,
    FORM_MODRM_RM     = 4'd3,
    FORM_MODRM_RM_REG = 4'd4,
    FORM_MODRM_REG_RM = 4'd5,
    FORM_MODRM_RM_IMM = 4'd6,
    FORM_EAX_IMM      = 4'd7,
    FORM_REG_IMM      = 4'd8
  } opnd_form_e;

  // Where a written operand goes
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_kind_e;

endpackage

// File: opnd_field_decode.sv
`timescale 1ns/1ps
`include "x86_opnd_params.svh"

module opnd_field_decode
  import x86_opnd_pkg::*;
(
  input  instr_bytes_t instr_bytes,
  input  opnd_form_e   opnd_form,
  input  logic         imm_1byte,
  output logic [7:0]   modrm,
  output logic [7:0]   sib,
  output logic         has_sib,
  output logic         rm_is_reg_direct,
  output logic         opnd0_from_rm,
  output logic         opnd0_from_reg,
  output logic         opnd0_from_opcode,
  output logic         opnd0_is_eax,
  output logic         opnd0_is_imm,
  output logic         opnd1_from_rm,
  output logic         opnd1_from_reg,
  output logic         opnd1_is_imm,
  output word_t        disp,
  output word_t        imm,
  output body_len_t    body_len
);

  logic       has_modrm;
  logic       has_imm;
  logic       is_disp8;
  logic       is_disp32;
  logic [1:0] mod_field;
  logic [2:0] rm_field;
  logic [3:0] disp_idx;
  logic [3:0] imm_idx;
  body_len_t  disp_len;
  body_len_t  imm_len;
  word_t      disp_word;
  word_t      imm_word;

  // Operand form decides which fields exist and where each operand comes from
  always_comb begin
    has_modrm         = 1'b0;
    has_imm           = 1'b0;
    opnd0_from_rm     = 1'b0;
    opnd0_from_reg    = 1'b0;
    opnd0_from_opcode = 1'b0;
    opnd0_is_eax      = 1'b0;
    opnd0_is_imm      = 1'b0;
    opnd1_from_rm     = 1'b0;
    opnd1_from_reg    = 1'b0;
    opnd1_is_imm      = 1'b0;
    case (opnd_form)
      FORM_REG: begin
        opnd0_from_opcode = 1'b1;
      end
      FORM_IMM: begin
        has_imm      = 1'b1;
        opnd0_is_imm = 1'b1;
      end
      FORM_MODRM_RM: begin
        has_modrm     = 1'b1;
        opnd0_from_rm = 1'b1;
      end
      FORM_MODRM_RM_REG: begin
        has_modrm      = 1'b1;
        opnd0_from_rm  = 1'b1;
        opnd1_from_reg = 1'b1;
      end
      FORM_MODRM_REG_RM: begin
        has_modrm      = 1'b1;
        opnd0_from_reg = 1'b1;
        opnd1_from_rm  = 1'b1;
      end
      FORM_MODRM_RM_IMM: begin
        has_modrm     = 1'b1;
        has_imm       = 1'b1;
        opnd0_from_rm = 1'b1;
        opnd1_is_imm  = 1'b1;
      end
      FORM_EAX_IMM: begin
        has_imm      = 1'b1;
        opnd0_is_eax = 1'b1;
        opnd1_is_imm = 1'b1;
      end
      FORM_REG_IMM: begin
        has_imm           = 1'b1;
        opnd0_from_opcode = 1'b1;
        opnd1_is_imm      = 1'b1;
      end
      default: begin
        has_imm = 1'b0;
      end
    endcase
  end

  // ModR/M always sits right after the opcode
  assign modrm     = has_modrm ? instr_bytes[15:8] : 8'h00;
  assign mod_field = modrm[7:6];
  assign rm_field  = modrm[2:0];

  assign rm_is_reg_direct = has_modrm && (mod_field == `X86_MOD_REG_DIRECT);

  // SIB only follows a memory form whose rm is 4
  assign has_sib = has_modrm && !rm_is_reg_direct && (rm_field == `X86_RM_SIB);
  assign sib     = has_sib ? instr_bytes[23:16] : 8'h00;

  // disp32 for mod 2, for absolute rm 5 under mod 0, and for SIB base 5 under mod 0
  assign is_disp8  = has_modrm && (mod_field == 2'd1);
  assign is_disp32 = has_modrm &&
                     ((mod_field == 2'd2) ||
                      ((mod_field == 2'd0) && !has_sib && (rm_field == `X86_RM_DISP32)) ||
                      ((mod_field == 2'd0) && has_sib && (sib[2:0] == `X86_SIB_NO_BASE)));

  assign disp_len = is_disp32 ? 4'd4 : (is_disp8 ? 4'd1 : 4'd0);
  assign imm_len  = !has_imm ? 4'd0 : (imm_1byte ? 4'd1 : 4'd4);

  // Byte positions of the displacement and the immediate
  assign disp_idx = 4'd1 + {3'b000, has_modrm} + {3'b000, has_sib};
  assign imm_idx  = disp_idx + disp_len;

  assign disp_word = instr_bytes[{disp_idx, 3'b000} +: 32];
  assign imm_word  = instr_bytes[{imm_idx, 3'b000} +: 32];

  // disp8 is sign-extended to a full word
  assign disp = is_disp32 ? disp_word :
                is_disp8  ? {{24{disp_word[7]}}, disp_word[7:0]} :
                            32'h0000_0000;

  // imm8 is sign-extended as well
  assign imm = !has_imm  ? 32'h0000_0000 :
               imm_1byte ? {{24{imm_word[7]}}, imm_word[7:0]} :
                           imm_word;

  assign body_len = {3'b000, has_modrm} + {3'b000, has_sib} + disp_len + imm_len;

endmodule

// File: opnd_fetch.sv
`timescale 1ns/1ps
`include "x86_opnd_params.svh"

module opnd_fetch
  import x86_opnd_pkg::*;
(
  input  instr_bytes_t instr_bytes,
  input  gpr_file_t    gpr,
  input  logic         is_lea,
  input  logic [7:0]   modrm,
  input  logic [7:0]   sib,
  input  logic         has_sib,
  input  logic         rm_is_reg_direct,
  input  logic         opnd0_from_rm,
  input  logic         opnd0_from_reg,
  input  logic         opnd0_from_opcode,
  input  logic         opnd0_is_eax,
  input  logic         opnd1_from_rm,
  input  logic         opnd1_from_reg,
  input  word_t        disp,
  input  logic         hint1_is_write,
  input  word_t        hint1_address,
  input  word_t        hint1_data,
  input  logic         hint2_is_write,
  input  word_t        hint2_address,
  input  word_t        hint2_data,
  output word_t        opnd0_regval,
  output word_t        opnd1_regval,
  output word_t        opnd0_memval,
  output word_t        opnd1_memval,
  output regsel_t      opnd0_regsel,
  output regsel_t      opnd1_regsel,
  output logic         opnd0_is_reg,
  output logic         opnd0_is_mem,
  output logic         opnd1_is_reg,
  output logic         opnd1_is_mem
);

  regsel_t    rm_sel;
  regsel_t    reg_sel;
  regsel_t    base_sel;
  regsel_t    index_sel;
  scale_t     scale;
  logic       base_absent;
  logic       index_absent;
  word_t      base_val;
  word_t      index_val;
  word_t      eff_addr;
  word_t      mem_val;

  assign rm_sel  = modrm[2:0];
  assign reg_sel = modrm[5:3];

  // Operand 0 selector, opcode bits win over rm, then reg
  // Implicit EAX and the no-register case both select 0
  assign opnd0_regsel = opnd0_from_opcode                    ? instr_bytes[2:0] :
                        (opnd0_from_rm && rm_is_reg_direct)  ? rm_sel :
                        opnd0_from_reg                       ? reg_sel :
                                                               3'd0;

  // Operand 1 never uses opcode bits or EAX in the kept forms
  assign opnd1_regsel = (opnd1_from_rm && rm_is_reg_direct) ? rm_sel :
                        opnd1_from_reg                      ? reg_sel :
                                                              3'd0;

  assign opnd0_is_reg = opnd0_from_opcode || opnd0_is_eax || opnd0_from_reg ||
                        (opnd0_from_rm && rm_is_reg_direct);
  assign opnd1_is_reg = opnd1_from_reg || (opnd1_from_rm && rm_is_reg_direct);

  // An rm operand outside register-direct mode is a memory operand
  assign opnd0_is_mem = opnd0_from_rm && !rm_is_reg_direct;
  assign opnd1_is_mem = opnd1_from_rm && !rm_is_reg_direct;

  assign opnd0_regval = gpr[opnd0_regsel];
  assign opnd1_regval = gpr[opnd1_regsel];

  // Base is the SIB base, or rm itself without SIB
  assign base_sel  = has_sib ? sib[2:0] : rm_sel;
  assign index_sel = sib[5:3];
  assign scale     = sib[7:6];

  // Under mod 0 the code 5 means disp32 with no base register
  assign base_absent = (modrm[7:6] == 2'd0) &&
                       (has_sib ? (sib[2:0] == `X86_SIB_NO_BASE) :
                                  (rm_sel == `X86_RM_DISP32));
  assign index_absent = !has_sib || (index_sel == `X86_SIB_NO_INDEX);

  assign base_val  = base_absent ? 32'h0000_0000 : gpr[base_sel];
  assign index_val = index_absent ? 32'h0000_0000 : (gpr[index_sel] << scale);
  assign eff_addr  = base_val + index_val + disp;

  // LEA returns the address, loads take the first read hint that matches
  assign mem_val = is_lea ? eff_addr :
                   (!hint1_is_write && (hint1_address == eff_addr)) ? hint1_data :
                   (!hint2_is_write && (hint2_address == eff_addr)) ? hint2_data :
                                                                      32'h0000_0000;

  // Both operands share the one ModR/M address
  assign opnd0_memval = opnd0_is_mem ? mem_val : 32'h0000_0000;
  assign opnd1_memval = opnd1_is_mem ? mem_val : 32'h0000_0000;

endmodule

// File: opnd_result_stage.sv
`timescale 1ns/1ps

module opnd_result_stage
  import x86_opnd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       instr_valid,
  input  logic       opnd0_is_write,
  input  logic       opnd1_is_write,
  input  word_t      opnd0_regval,
  input  word_t      opnd1_regval,
  input  word_t      opnd0_memval,
  input  word_t      opnd1_memval,
  input  regsel_t    opnd0_regsel,
  input  regsel_t    opnd1_regsel,
  input  logic       opnd0_is_reg,
  input  logic       opnd0_is_mem,
  input  logic       opnd1_is_reg,
  input  logic       opnd1_is_mem,
  input  logic       opnd0_is_imm,
  input  logic       opnd1_is_imm,
  input  word_t      imm,
  input  body_len_t  body_len,
  output logic       opnd_valid,
  output word_t      opnd0,
  output word_t      opnd1,
  output dest_kind_e dest0_kind,
  output dest_kind_e dest1_kind,
  output regsel_t    dest0_sel,
  output regsel_t    dest1_sel,
  output body_len_t  instr_body_len
);

  word_t      opnd0_next;
  word_t      opnd1_next;
  dest_kind_e dest0_kind_next;
  dest_kind_e dest1_kind_next;

  // Register beats memory beats immediate, zero when none applies
  assign opnd0_next = opnd0_is_reg ? opnd0_regval :
                      opnd0_is_mem ? opnd0_memval :
                      opnd0_is_imm ? imm :
                                     32'h0000_0000;
  assign opnd1_next = opnd1_is_reg ? opnd1_regval :
                      opnd1_is_mem ? opnd1_memval :
                      opnd1_is_imm ? imm :
                                     32'h0000_0000;

  // Only written operands have a destination, an immediate never does
  assign dest0_kind_next = !opnd0_is_write ? DEST_NONE :
                           opnd0_is_reg    ? DEST_REG :
                           opnd0_is_mem    ? DEST_MEM :
                                             DEST_NONE;
  assign dest1_kind_next = !opnd1_is_write ? DEST_NONE :
                           opnd1_is_reg    ? DEST_REG :
                           opnd1_is_mem    ? DEST_MEM :
                                             DEST_NONE;

  // One output register stage, loaded by instr_valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opnd_valid     <= 1'b0;
      opnd0          <= 32'h0000_0000;
      opnd1          <= 32'h0000_0000;
      dest0_kind     <= DEST_NONE;
      dest1_kind     <= DEST_NONE;
      dest0_sel      <= 3'd0;
      dest1_sel      <= 3'd0;
      instr_body_len <= '0;
    end else begin
      opnd_valid <= instr_valid;
      if (instr_valid) begin
        opnd0          <= opnd0_next;
        opnd1          <= opnd1_next;
        dest0_kind     <= dest0_kind_next;
        dest1_kind     <= dest1_kind_next;
        // Selector only carries meaning for a register destination
        dest0_sel      <= (dest0_kind_next == DEST_REG) ? opnd0_regsel : 3'd0;
        dest1_sel      <= (dest1_kind_next == DEST_REG) ? opnd1_regsel : 3'd0;
        instr_body_len <= body_len;
      end
    end
  end

endmodule

// File: decode_opnds_top.sv
`timescale 1ns/1ps

module decode_opnds_top
  import x86_opnd_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         instr_valid,
  input  instr_bytes_t instr_bytes,
  input  opnd_form_e   opnd_form,
  input  logic         imm_1byte,
  input  logic         is_lea,
  input  logic         opnd0_is_write,
  input  logic         opnd1_is_write,
  input  gpr_file_t    gpr,
  input  logic         hint1_is_write,
  input  word_t        hint1_address,
  input  word_t        hint1_data,
  input  logic         hint2_is_write,
  input  word_t        hint2_address,
  input  word_t        hint2_data,
  output logic         opnd_valid,
  output word_t        opnd0,
  output word_t        opnd1,
  output dest_kind_e   dest0_kind,
  output dest_kind_e   dest1_kind,
  output regsel_t      dest0_sel,
  output regsel_t      dest1_sel,
  output body_len_t    instr_body_len
);

  // Decode to fetch and result
  logic [7:0] modrm;
  logic [7:0] sib;
  logic       has_sib;
  logic       rm_is_reg_direct;
  logic       opnd0_from_rm;
  logic       opnd0_from_reg;
  logic       opnd0_from_opcode;
  logic       opnd0_is_eax;
  logic       opnd0_is_imm;
  logic       opnd1_from_rm;
  logic       opnd1_from_reg;
  logic       opnd1_is_imm;
  word_t      disp;
  word_t      imm;
  body_len_t  body_len;

  // Fetch to result
  word_t      opnd0_regval;
  word_t      opnd1_regval;
  word_t      opnd0_memval;
  word_t      opnd1_memval;
  regsel_t    opnd0_regsel;
  regsel_t    opnd1_regsel;
  logic       opnd0_is_reg;
  logic       opnd0_is_mem;
  logic       opnd1_is_reg;
  logic       opnd1_is_mem;

  opnd_field_decode u_decode (
    .instr_bytes       (instr_bytes),
    .opnd_form         (opnd_form),
    .imm_1byte         (imm_1byte),
    .modrm             (modrm),
    .sib               (sib),
    .has_sib           (has_sib),
    .rm_is_reg_direct  (rm_is_reg_direct),
    .opnd0_from_rm     (opnd0_from_rm),
    .opnd0_from_reg    (opnd0_from_reg),
    .opnd0_from_opcode (opnd0_from_opcode),
    .opnd0_is_eax      (opnd0_is_eax),
    .opnd0_is_imm      (opnd0_is_imm),
    .opnd1_from_rm     (opnd1_from_rm),
    .opnd1_from_reg    (opnd1_from_reg),
    .opnd1_is_imm      (opnd1_is_imm),
    .disp              (disp),
    .imm               (imm),
    .body_len          (body_len)
  );

  opnd_fetch u_fetch (
    .instr_bytes       (instr_bytes),
    .gpr               (gpr),
    .is_lea            (is_lea),
    .modrm             (modrm),
    .sib               (sib),
    .has_sib           (has_sib),
    .rm_is_reg_direct  (rm_is_reg_direct),
    .opnd0_from_rm     (opnd0_from_rm),
    .opnd0_from_reg    (opnd0_from_reg),
    .opnd0_from_opcode (opnd0_from_opcode),
    .opnd0_is_eax      (opnd0_is_eax),
    .opnd1_from_rm     (opnd1_from_rm),
    .opnd1_from_reg    (opnd1_from_reg),
    .disp              (disp),
    .hint1_is_write    (hint1_is_write),
    .hint1_address     (hint1_address),
    .hint1_data        (hint1_data),
    .hint2_is_write    (hint2_is_write),
    .hint2_address     (hint2_address),
    .hint2_data        (hint2_data),
    .opnd0_regval      (opnd0_regval),
    .opnd1_regval      (opnd1_regval),
    .opnd0_memval      (opnd0_memval),
    .opnd1_memval      (opnd1_memval),
    .opnd0_regsel      (opnd0_regsel),
    .opnd1_regsel      (opnd1_regsel),
    .opnd0_is_reg      (opnd0_is_reg),
    .opnd0_is_mem      (opnd0_is_mem),
    .opnd1_is_reg      (opnd1_is_reg),
    .opnd1_is_mem      (opnd1_is_mem)
  );

  opnd_result_stage u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .opnd0_is_write (opnd0_is_write),
    .opnd1_is_write (opnd1_is_write),
    .opnd0_regval   (opnd0_regval),
    .opnd1_regval   (opnd1_regval),
    .opnd0_memval   (opnd0_memval),
    .opnd1_memval   (opnd1_memval),
    .opnd0_regsel   (opnd0_regsel),
    .opnd1_regsel   (opnd1_regsel),
    .opnd0_is_reg   (opnd0_is_reg),
    .opnd0_is_mem   (opnd0_is_mem),
    .opnd1_is_reg   (opnd1_is_reg),
    .opnd1_is_mem   (opnd1_is_mem),
    .opnd0_is_imm   (opnd0_is_imm),
    .opnd1_is_imm   (opnd1_is_imm),
    .imm            (imm),
    .body_len       (body_len),
    .opnd_valid     (opnd_valid),
    .opnd0          (opnd0),
    .opnd1          (opnd1),
    .dest0_kind     (dest0_kind),
    .dest1_kind     (dest1_kind),
    .dest0_sel      (dest0_sel),
    .dest1_sel      (dest1_sel),
    .instr_body_len (instr_body_len)
  );

endmodule

// File: tb_decode_opnds.sv
`timescale 1ns/1ps
`include "x86_opnd_params.svh"

module tb_decode_opnds
  import x86_opnd_pkg::*;
();

  // Expected outputs packed as opnd0, opnd1, dest kinds, dest selectors and body length
  typedef logic [77:0] exp_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         instr_valid;
  instr_bytes_t instr_bytes;
  opnd_form_e   opnd_form;
  logic         imm_1byte;
  logic         is_lea;
  logic         opnd0_is_write;
  logic         opnd1_is_write;
  gpr_file_t    gpr;
  logic         hint1_is_write;
  word_t        hint1_address;
  word_t        hint1_data;
  logic         hint2_is_write;
  word_t        hint2_address;
  word_t        hint2_data;
  logic         opnd_valid;
  word_t        opnd0;
  word_t        opnd1;
  dest_kind_e   dest0_kind;
  dest_kind_e   dest1_kind;
  regsel_t      dest0_sel;
  regsel_t      dest1_sel;
  body_len_t    instr_body_len;

  // Register file and hints for the next applied item
  gpr_file_t    regs;
  logic         h1_write;
  word_t        h1_addr;
  word_t        h1_data;
  logic         h2_write;
  word_t        h2_addr;
  word_t        h2_data;

  // Outstanding items, each with its name and the cycle its result is due
  exp_t         exp_q[$];
  string        name_q[$];
  int           due_q[$];
  int           cyc = 0;
  integer       seed;
  exp_t         head;
  string        head_name;
  int           head_due;

  decode_opnds_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .instr_bytes    (instr_bytes),
    .opnd_form      (opnd_form),
    .imm_1byte      (imm_1byte),
    .is_lea         (is_lea),
    .opnd0_is_write (opnd0_is_write),
    .opnd1_is_write (opnd1_is_write),
    .gpr            (gpr),
    .hint1_is_write (hint1_is_write),
    .hint1_address  (hint1_address),
    .hint1_data     (hint1_data),
    .hint2_is_write (hint2_is_write),
    .hint2_address  (hint2_address),
    .hint2_data     (hint2_data),
    .opnd_valid     (opnd_valid),
    .opnd0          (opnd0),
    .opnd1          (opnd1),
    .dest0_kind     (dest0_kind),
    .dest1_kind     (dest1_kind),
    .dest0_sel      (dest0_sel),
    .dest1_sel      (dest1_sel),
    .instr_body_len (instr_body_len)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic word_t sext8(logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  // Displacement bytes of a memory ModR/M, valid only when mod is not 3
  function automatic int disp_length(logic [7:0] m, logic [7:0] s);
    if (m[7:6] == 2'd1) return 1;
    if (m[7:6] == 2'd2) return 4;
    if (m[7:6] == 2'd0 && m[2:0] == `X86_RM_DISP32) return 4;
    if (m[7:6] == 2'd0 && m[2:0] == `X86_RM_SIB && s[2:0] == `X86_SIB_NO_BASE) return 4;
    return 0;
  endfunction

  // Base plus scaled index plus displacement of the ModR/M memory operand
  function automatic word_t ref_address(instr_bytes_t b, gpr_file_t g);
    logic [7:0]   m;
    logic [7:0]   s;
    logic         sib_on;
    instr_bytes_t rest;
    word_t        disp;
    word_t        base;
    word_t        index;
    m = b[15:8];
    s = b[23:16];
    sib_on = (m[2:0] == `X86_RM_SIB);
    rest = b >> (sib_on ? 24 : 16);
    case (disp_length(m, s))
      1: disp = sext8(rest[7:0]);
      4: disp = rest[31:0];
      default: disp = 0;
    endcase
    base = sib_on ? g[s[2:0]] : g[m[2:0]];
    // Code 5 under mod 0 drops the base register
    if (m[7:6] == 2'd0 && (sib_on ? s[2:0] == `X86_SIB_NO_BASE : m[2:0] == `X86_RM_DISP32))
      base = 0;
    index = (sib_on && s[5:3] != `X86_SIB_NO_INDEX) ? g[s[5:3]] << s[7:6] : 0;
    return base + index + disp;
  endfunction

  function automatic exp_t expect_opnds(opnd_form_e form, instr_bytes_t b, logic imm8,
      logic lea, logic w0, logic w1, gpr_file_t g, logic h1w, word_t h1a, word_t h1d,
      logic h2w, word_t h2a, word_t h2d);
    logic [7:0]   m;
    logic         direct;
    instr_bytes_t rest;
    int           len;
    int           kind0;
    int           kind1;
    regsel_t      sel0;
    regsel_t      sel1;
    word_t        addr;
    word_t        mem;
    word_t        imm;
    word_t        v0;
    word_t        v1;
    dest_kind_e   d0;
    dest_kind_e   d1;
    m = b[15:8];
    direct = (m[7:6] == `X86_MOD_REG_DIRECT);
    len = 0;
    if (form inside {FORM_MODRM_RM, FORM_MODRM_RM_REG, FORM_MODRM_REG_RM, FORM_MODRM_RM_IMM}) begin
      len = 1;
      if (!direct)
        len += ((m[2:0] == `X86_RM_SIB) ? 1 : 0) + disp_length(m, b[23:16]);
    end
    // The immediate follows every other body field
    imm = 0;
    if (form inside {FORM_IMM, FORM_MODRM_RM_IMM, FORM_EAX_IMM, FORM_REG_IMM}) begin
      rest = b >> (8 * (len + 1));
      imm = imm8 ? sext8(rest[7:0]) : rest[31:0];
      len += imm8 ? 1 : 4;
    end
    addr = ref_address(b, g);
    mem = lea ? addr : (!h1w && h1a == addr) ? h1d : (!h2w && h2a == addr) ? h2d : 0;
    // Kinds are 0 for none, 1 for register, 2 for memory and 3 for immediate
    case (form)
      FORM_REG, FORM_REG_IMM, FORM_EAX_IMM, FORM_MODRM_REG_RM: kind0 = 1;
      FORM_IMM: kind0 = 3;
      FORM_MODRM_RM, FORM_MODRM_RM_REG, FORM_MODRM_RM_IMM: kind0 = direct ? 1 : 2;
      default: kind0 = 0;
    endcase
    case (form)
      FORM_MODRM_RM_REG: kind1 = 1;
      FORM_MODRM_REG_RM: kind1 = direct ? 1 : 2;
      FORM_MODRM_RM_IMM, FORM_EAX_IMM, FORM_REG_IMM: kind1 = 3;
      default: kind1 = 0;
    endcase
    sel0 = (form inside {FORM_REG, FORM_REG_IMM}) ? b[2:0] :
           (form == FORM_EAX_IMM) ? 3'd0 :
           (form == FORM_MODRM_REG_RM) ? m[5:3] : m[2:0];
    sel1 = (form == FORM_MODRM_RM_REG) ? m[5:3] : m[2:0];
    v0 = (kind0 == 1) ? g[sel0] : (kind0 == 2) ? mem : (kind0 == 3) ? imm : 0;
    v1 = (kind1 == 1) ? g[sel1] : (kind1 == 2) ? mem : (kind1 == 3) ? imm : 0;
    d0 = (!w0 || kind0 == 0 || kind0 == 3) ? DEST_NONE : (kind0 == 1) ? DEST_REG : DEST_MEM;
    d1 = (!w1 || kind1 == 0 || kind1 == 3) ? DEST_NONE : (kind1 == 1) ? DEST_REG : DEST_MEM;
    return {v0, v1, d0, d1, (d0 == DEST_REG) ? sel0 : 3'd0, (d1 == DEST_REG) ? sel1 : 3'd0,
            body_len_t'(len)};
  endfunction

  // Tail holds the displacement and then the immediate, lowest byte first
  function automatic instr_bytes_t make_instr(logic [7:0] op, logic has_m, logic [7:0] m,
      logic has_s, logic [7:0] s, logic [63:0] tail);
    if (has_s) return {tail, s, m, op};
    if (has_m) return {8'h00, tail, m, op};
    return {16'h0000, tail, op};
  endfunction

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(string test, string field, word_t exp_val, word_t act_val);
    assert (act_val === exp_val) else begin
      $display("Error: test %s, %s expected %h actual %h", test, field, exp_val, act_val);
      stop_on_error();
    end
  endtask

  task automatic set_hints(logic w1, word_t a1, word_t d1, logic w2, word_t a2, word_t d2);
    h1_write = w1;
    h1_addr  = a1;
    h1_data  = d1;
    h2_write = w2;
    h2_addr  = a2;
    h2_data  = d2;
  endtask

  // Driven at one edge and captured at the next, so the result is checked two counts on
  task automatic apply_item(string name, opnd_form_e form, instr_bytes_t b, logic imm8,
      logic lea, logic w0, logic w1);
    @(posedge clk);
    instr_valid    <= 1'b1;
    instr_bytes    <= b;
    opnd_form      <= form;
    imm_1byte      <= imm8;
    is_lea         <= lea;
    opnd0_is_write <= w0;
    opnd1_is_write <= w1;
    gpr            <= regs;
    hint1_is_write <= h1_write;
    hint1_address  <= h1_addr;
    hint1_data     <= h1_data;
    hint2_is_write <= h2_write;
    hint2_address  <= h2_addr;
    hint2_data     <= h2_data;
    exp_q.push_back(expect_opnds(form, b, imm8, lea, w0, w1, regs, h1_write, h1_addr,
                                 h1_data, h2_write, h2_addr, h2_data));
    name_q.push_back(name);
    due_q.push_back(cyc + 2);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they settle
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!opnd_valid && dest0_kind == DEST_NONE && dest1_kind == DEST_NONE &&
              opnd0 == 0 && opnd1 == 0) else begin
        $display("Outputs are not cleared while reset is asserted");
        stop_on_error();
      end
    end else if (opnd_valid) begin
      assert (due_q.size() > 0) else begin
        $display("opnd_valid went high with no instruction outstanding");
        stop_on_error();
      end
      head = exp_q.pop_front();
      head_name = name_q.pop_front();
      head_due = due_q.pop_front();
      assert (cyc == head_due) else begin
        $display("Result of test %s arrived at count %0d, due at %0d", head_name, cyc, head_due);
        stop_on_error();
      end
      check_value(head_name, "opnd0", head[77:46], opnd0);
      check_value(head_name, "opnd1", head[45:14], opnd1);
      check_value(head_name, "dest0_kind", 32'(head[13:12]), 32'(dest0_kind));
      check_value(head_name, "dest1_kind", 32'(head[11:10]), 32'(dest1_kind));
      check_value(head_name, "dest0_sel", 32'(head[9:7]), 32'(dest0_sel));
      check_value(head_name, "dest1_sel", 32'(head[6:4]), 32'(dest1_sel));
      check_value(head_name, "instr_body_len", 32'(head[3:0]), 32'(instr_body_len));
    end else begin
      assert (due_q.size() == 0 || due_q[0] > cyc) else begin
        $display("opnd_valid stayed low when the result of test %s was due", name_q[0]);
        stop_on_error();
      end
    end
  end

  initial begin : stimulus
    logic [31:0]  r;
    logic [31:0]  r2;
    instr_bytes_t rb;
    opnd_form_e   form;
    word_t        addr;
    int           wait_cycles;
    seed           = 32'h43662721;
    rst_n          = 1'b0;
    instr_valid    = 1'b0;
    instr_bytes    = '0;
    opnd_form      = FORM_NONE;
    imm_1byte      = 1'b0;
    is_lea         = 1'b0;
    opnd0_is_write = 1'b0;
    opnd1_is_write = 1'b0;
    gpr            = '0;
    hint1_is_write = 1'b0;
    hint1_address  = '0;
    hint1_data     = '0;
    hint2_is_write = 1'b0;
    hint2_address  = '0;
    hint2_data     = '0;
    for (int n = 0; n < 8; n++)
      regs[n] = 32'h1111_0000 + n * 32'h100;
    set_hints(1'b1, 32'h0, 32'h0, 1'b1, 32'h0, 32'h0);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycle();

    // Register forms, back to back
    apply_item("reg_opcode_bits", FORM_REG, make_instr(8'h43, 0, 0, 0, 0, 0), 0, 0, 1, 0);
    apply_item("rm_reg_direct", FORM_MODRM_RM_REG, make_instr(8'h89, 1, 8'hCA, 0, 0, 0),
               0, 0, 1, 1);
    apply_item("reg_rm_direct", FORM_MODRM_REG_RM, make_instr(8'h8B, 1, 8'hF7, 0, 0, 0),
               0, 0, 1, 0);
    apply_item("eax_imm32", FORM_EAX_IMM, make_instr(8'h05, 0, 0, 0, 0, 64'h1234_5678),
               0, 0, 1, 0);
    idle_cycle();

    // Memory operands through the hints, a write hint never supplies data
    set_hints(1'b0, regs[3], 32'hDEAD_BEEF, 1'b0, 32'h0, 32'h0);
    apply_item("mem_mod0", FORM_MODRM_RM_REG, make_instr(8'h89, 1, 8'h0B, 0, 0, 0), 0, 0, 1, 0);
    set_hints(1'b1, regs[6] - 16, 32'h0BAD_0001, 1'b0, regs[6] - 16, 32'h600D_0002);
    apply_item("mem_mod1_disp8", FORM_MODRM_RM_REG, make_instr(8'h01, 1, 8'h46, 0, 0, 64'hF0),
               0, 0, 1, 0);
    idle_cycle();
    idle_cycle();
    apply_item("mem_mod2_miss", FORM_MODRM_REG_RM, make_instr(8'h8B, 1, 8'h91, 0, 0, 64'h400),
               0, 0, 1, 1);
    set_hints(1'b0, 32'h0000_8000, 32'hA5A5_0033, 1'b0, 32'h0000_8000, 32'h0);
    apply_item("mem_abs_disp32", FORM_MODRM_RM, make_instr(8'hFF, 1, 8'h05, 0, 0, 64'h8000),
               0, 0, 1, 0);

    // SIB addresses observed through LEA
    apply_item("sib_scale_disp8", FORM_MODRM_RM, make_instr(8'h8D, 1, 8'h44, 1, 8'h8B, 64'h08),
               0, 1, 0, 0);
    apply_item("sib_no_index", FORM_MODRM_RM, make_instr(8'h8D, 1, 8'h84, 1, 8'h62, 64'h100),
               0, 1, 0, 0);
    apply_item("sib_no_base", FORM_MODRM_RM, make_instr(8'h8D, 1, 8'h04, 1, 8'hFD, 64'h2000),
               0, 1, 0, 0);
    apply_item("sib_mod0", FORM_MODRM_RM, make_instr(8'h8D, 1, 8'h0C, 1, 8'h30, 0), 0, 1, 0, 0);

    // Immediates and body lengths
    apply_item("imm8_sext", FORM_IMM, make_instr(8'h6A, 0, 0, 0, 0, 64'h80), 1, 0, 0, 0);
    apply_item("imm32", FORM_IMM, make_instr(8'h68, 0, 0, 0, 0, 64'h8000_0001), 0, 0, 0, 0);
    apply_item("reg_imm8", FORM_REG_IMM, make_instr(8'hB9, 0, 0, 0, 0, 64'h7F), 1, 0, 1, 0);
    apply_item("rm_imm32_sib_disp32", FORM_MODRM_RM_IMM,
               make_instr(8'hC7, 1, 8'h84, 1, 8'h62, 64'hCAFE_F00D_0000_0010), 0, 0, 1, 0);
    apply_item("rm_imm8_direct", FORM_MODRM_RM_IMM, make_instr(8'h83, 1, 8'hC0, 0, 0, 64'hFE),
               1, 0, 1, 0);

    // Random items, with hints aimed at the address about half of the time
    for (int i = 0; i < 400; i++) begin
      if (i % 16 == 0) begin
        for (int n = 0; n < 8; n++)
          regs[n] = $random(seed);
      end
      r = $random(seed);
      rb[31:0] = $random(seed);
      rb[63:32] = $random(seed);
      r2 = $random(seed);
      rb[87:64] = r2[23:0];
      form = opnd_form_e'(4'(r % 32'd9));
      addr = ref_address(rb, regs);
      r2 = $random(seed);
      set_hints(r[10], r[11] ? addr : r2, $random(seed), r[12], r[13] ? addr : ~r2,
                $random(seed));
      if (r[15:14] == 2'b00)
        idle_cycle();
      apply_item("random", form, rb, r[9], r[8], r[6], r[7]);
    end
    idle_cycle();

    // Drain the outstanding results
    wait_cycles = 0;
    while (due_q.size() > 0 && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (due_q.size() > 0) begin
      $display("Timed out with %0d results never delivered", due_q.size());
      $display("TB FAILED");
      $fatal(1, "drain timeout");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: filelist.f
+incdir+.
x86_opnd_pkg.sv
opnd_field_decode.sv
opnd_fetch.sv
opnd_result_stage.sv
decode_opnds_top.sv
tb_decode_opnds.sv

// File: Makefile
TOP = tb_decode_opnds

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
